/* src/spl_pkg.sv */
// --------------------------------------------------------------------
// shared geometry and codes for the 2-of-7 link sender
// symbol = {eop flag, nibble}; link state is the raw 7-wire NRZ level
// --------------------------------------------------------------------
`default_nettype none

package spl_pkg;

  // packet geometry
  localparam int pkt_bits      = 72;
  localparam int nibble_bits   = 4;
  localparam int short_nibbles = 10;  // 40-bit packet
  localparam int long_nibbles  = 18;  // 72-bit packet
  localparam int len_bit       = 1;   // high marks a long packet

  typedef logic [nibble_bits:0] sym_t;  // msb = end-of-packet
  typedef logic [6:0]           link_t; // link wire levels

  // --------------------------------------------------------------------
  // two-hot transition patterns, xored into the wire state
  // index 0..15 nibble values, 16 end-of-packet
  // --------------------------------------------------------------------
  localparam link_t nrz_code [17] = '{
    7'b0010001,  // 0
    7'b0010010,  // 1
    7'b0010100,  // 2
    7'b0011000,  // 3
    7'b0100001,  // 4
    7'b0100010,  // 5
    7'b0100100,  // 6
    7'b0101000,  // 7
    7'b1000001,  // 8
    7'b1000010,  // 9
    7'b1000100,  // 10
    7'b1001000,  // 11
    7'b0000011,  // 12
    7'b0000110,  // 13
    7'b0001100,  // 14
    7'b0001001,  // 15
    7'b1100000   // eop
  };

endpackage

`default_nettype wire

/* src/spl_pkt_serializer.sv */
// --------------------------------------------------------------------
// one packet at a time, nibbles lsb first, then an eop symbol
// pushes only while fifo credits remain, credits start at fifo_depth
// --------------------------------------------------------------------
`default_nettype none

module spl_pkt_serializer #(
  parameter int fifo_depth = 4
) (
  input  wire                         CLK_IN,
  input  wire                         RESET_IN,
  input  wire [spl_pkg::pkt_bits-1:0] pkt_data,
  input  wire                         pkt_vld,
  output logic                        pkt_rdy,
  output spl_pkg::sym_t               sym,
  output logic                        sym_push,
  input  wire                         sym_credit
);
  import spl_pkg::*;

  localparam int cnt_bits  = $clog2(long_nibbles + 1);
  localparam int cred_bits = $clog2(fifo_depth + 1);

  logic [pkt_bits-1:0]  pkt_buf;   // shifts right as nibbles leave
  logic                 pkt_long;  // length flag of current packet
  logic [cnt_bits-1:0]  nib_cnt;   // nibbles pushed so far
  logic [cred_bits-1:0] credits;   // free fifo slots as seen here
  logic                 accept;
  logic                 eop;       // all nibbles out, eop is next

  // --------------------------------------------------------------------
  // handshake and symbol select
  // --------------------------------------------------------------------
  assign accept = pkt_vld && pkt_rdy;
  assign eop    = (nib_cnt == (pkt_long ? cnt_bits'(long_nibbles)
                                        : cnt_bits'(short_nibbles)));

  // busy whenever not ready, stall on zero credits
  assign sym_push = !pkt_rdy && (credits != '0);
  assign sym      = eop ? {1'b1, {nibble_bits{1'b0}}}
                        : {1'b0, pkt_buf[nibble_bits-1:0]};

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_rdy <= 1'b1;
    end else if (accept) begin
      pkt_rdy <= 1'b0;                 // low from next cycle
    end else if (sym_push && eop) begin
      pkt_rdy <= 1'b1;                 // eop gone, take the next one
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_long <= 1'b0;
      nib_cnt  <= '0;
    end else if (accept) begin
      pkt_long <= pkt_data[len_bit];
      nib_cnt  <= '0;
    end else if (sym_push && !eop) begin
      nib_cnt  <= nib_cnt + 1'b1;
    end
  end

  // packet payload
  always_ff @(posedge CLK_IN) begin
    if (accept) begin
      pkt_buf <= pkt_data;
    end else if (sym_push && !eop) begin
      pkt_buf <= pkt_buf >> nibble_bits;  // next nibble to the bottom
    end
  end

  // --------------------------------------------------------------------
  // fifo credits
  // --------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      credits <= cred_bits'(fifo_depth);  // fifo empty at start
    end else begin
      case ({sym_push, sym_credit})
        2'b10:   credits <= credits - 1'b1;  // slot taken
        2'b01:   credits <= credits + 1'b1;  // slot freed by a pop
        default: credits <= credits;         // none or both
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/spl_symbol_fifo.sv */
// --------------------------------------------------------------------
// circular symbol buffer, head readable one cycle after push
// no overflow guard, the producer's credit count prevents it
// --------------------------------------------------------------------
`default_nettype none

module spl_symbol_fifo #(
  parameter int fifo_depth = 4
) (
  input  wire                CLK_IN,
  input  wire                RESET_IN,
  input  wire spl_pkg::sym_t sym,
  input  wire                sym_push,
  input  wire                pop,
  output spl_pkg::sym_t      head,
  output logic               head_vld,
  output logic               sym_credit
);
  import spl_pkg::*;

  localparam int ptr_bits  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int fill_bits = $clog2(fifo_depth + 1);

  sym_t                 mem [fifo_depth];
  logic [ptr_bits-1:0]  wr_ptr;
  logic [ptr_bits-1:0]  rd_ptr;
  logic [fill_bits-1:0] fill;   // occupancy

  // wrap at depth, works for any depth
  function automatic logic [ptr_bits-1:0] ptr_next(input logic [ptr_bits-1:0] p);
    ptr_next = (p == ptr_bits'(fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head     = mem[rd_ptr];
  assign head_vld = (fill != '0);

  always_ff @(posedge CLK_IN) begin
    if (sym_push) begin
      mem[wr_ptr] <= sym;
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      sym_credit <= 1'b0;
    end else begin
      if (sym_push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)      rd_ptr <= ptr_next(rd_ptr);
      case ({sym_push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      sym_credit <= pop;  // one credit back per pop, a cycle later
    end
  end

endmodule

`default_nettype wire

/* src/spl_link_transmitter.sv */
// --------------------------------------------------------------------
// nrz 2-of-7 link driver, link_ack is asynchronous (2-flop sync)
// at most ack_window symbols in flight, credit count starts full
// --------------------------------------------------------------------
`default_nettype none

module spl_link_transmitter #(
  parameter int ack_window = 1
) (
  input  wire                CLK_IN,
  input  wire                RESET_IN,
  input  wire spl_pkg::sym_t head,
  input  wire                head_vld,
  output logic               pop,
  output spl_pkg::link_t     link_data,
  input  wire                link_ack
);
  import spl_pkg::*;

  localparam int win_bits = $clog2(ack_window + 1);
  localparam int eop_idx  = 2 ** nibble_bits;  // code entry after the nibbles
  localparam int idx_bits = $clog2(eop_idx + 1);

  logic                ack_meta;    // first sync stage
  logic                ack_sync;    // second sync stage
  logic                ack_prev;    // for edge detect
  logic                ack_toggle;
  logic                ack_ret;     // toggle that retires a symbol
  logic [win_bits-1:0] unacked;     // symbols sent, not yet acked
  logic [idx_bits-1:0] code_idx;

  // --------------------------------------------------------------------
  // acknowledge synchronizer and toggle detect
  // --------------------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_meta <= 1'b0;
      ack_sync <= 1'b0;
      ack_prev <= 1'b0;
    end else begin
      ack_meta <= link_ack;
      ack_sync <= ack_meta;
      ack_prev <= ack_sync;
    end
  end

  assign ack_toggle = ack_sync ^ ack_prev;   // either edge is one ack
  assign ack_ret    = ack_toggle && (unacked != '0);  // ignore stray acks

  // --------------------------------------------------------------------
  // window and pop
  // --------------------------------------------------------------------
  assign pop = head_vld && (unacked < win_bits'(ack_window));

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      unacked <= '0;
    end else begin
      case ({pop, ack_ret})
        2'b10:   unacked <= unacked + 1'b1;  // one more in flight
        2'b01:   unacked <= unacked - 1'b1;  // receiver took one
        default: unacked <= unacked;         // sent and acked together
      endcase
    end
  end

  // --------------------------------------------------------------------
  // nrz encoder
  // --------------------------------------------------------------------
  // eop flag overrides the nibble bits
  assign code_idx = head[nibble_bits] ? idx_bits'(eop_idx)
                                      : idx_bits'(head[nibble_bits-1:0]);

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      link_data <= '0;
    end else if (pop) begin
      link_data <= link_data ^ nrz_code[code_idx];  // flip two wires
    end
  end

endmodule

`default_nettype wire

/* src/spl_link_sender.sv */
// --------------------------------------------------------------------
// packet in, 2-of-7 link out: serializer -> symbol fifo -> transmitter
// --------------------------------------------------------------------
`default_nettype none

module spl_link_sender #(
  parameter int fifo_depth = 4,  // symbol buffer slots
  parameter int ack_window = 1   // symbols in flight on the link
) (
  input  wire                         CLK_IN,
  input  wire                         RESET_IN,
  input  wire [spl_pkg::pkt_bits-1:0] pkt_data,
  input  wire                         pkt_vld,
  output wire                         pkt_rdy,
  output wire spl_pkg::link_t         link_data,
  input  wire                         link_ack
);
  import spl_pkg::*;

  sym_t sym;         // serializer -> fifo
  logic sym_push;
  logic sym_credit;  // fifo -> serializer, one per pop
  sym_t head;        // fifo -> transmitter
  logic head_vld;
  logic pop;

  spl_pkt_serializer #(.fifo_depth(fifo_depth)) u_serializer (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .pkt_data   (pkt_data),
    .pkt_vld    (pkt_vld),
    .pkt_rdy    (pkt_rdy),
    .sym        (sym),
    .sym_push   (sym_push),
    .sym_credit (sym_credit)
  );

  spl_symbol_fifo #(.fifo_depth(fifo_depth)) u_fifo (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .sym        (sym),
    .sym_push   (sym_push),
    .pop        (pop),
    .head       (head),
    .head_vld   (head_vld),
    .sym_credit (sym_credit)
  );

  spl_link_transmitter #(.ack_window(ack_window)) u_transmitter (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .head      (head),
    .head_vld  (head_vld),
    .pop       (pop),
    .link_data (link_data),
    .link_ack  (link_ack)
  );

endmodule

`default_nettype wire

/* tb/spl_link_sender_assert.sv */
// ----------------------------------------------------------------------
// link and fifo rules, bound into transmitter and fifo
// each binding ties the inputs of the other block's rules to idle
// ----------------------------------------------------------------------
`default_nettype none

module spl_link_sender_assert #(
  parameter int window = 1  // symbols allowed in flight
) (
  input wire                 CLK_IN,
  input wire                 RESET_IN,
  input wire spl_pkg::link_t link_data,
  input wire                 link_sent,   // symbol leaves for the link
  input wire                 link_acked,  // synchronized ack toggle
  input wire                 fifo_full,
  input wire                 fifo_push
);

  int   in_flight;   // own count, wide enough to show an overrun
  logic ack_counts;

  assign ack_counts = link_acked && (in_flight > 0);  // stray acks retire nothing

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      in_flight <= 0;
    end else if (link_sent && !ack_counts) begin
      in_flight <= in_flight + 1;
    end else if (!link_sent && ack_counts) begin
      in_flight <= in_flight - 1;
    end
  end

  // nrz 2-of-7, every symbol flips exactly two wires
  a_two_wires: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
      (link_data != $past(link_data)) |-> ($countones(link_data ^ $past(link_data)) == 2))
    else $error("link_data changed on other than two wires");

  a_no_overflow: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
      !(fifo_push && fifo_full))
    else $error("symbol fifo pushed while full");

  a_window: assert property (@(posedge CLK_IN) disable iff (RESET_IN) in_flight <= window)
    else $error("unacknowledged symbols exceed ack_window");

endmodule

bind spl_link_transmitter spl_link_sender_assert #(.window(ack_window)) u_link_rules (
  .CLK_IN     (CLK_IN),
  .RESET_IN   (RESET_IN),
  .link_data  (link_data),
  .link_sent  (pop),
  .link_acked (ack_toggle),
  .fifo_full  (1'b0),
  .fifo_push  (1'b0)
);

bind spl_symbol_fifo spl_link_sender_assert u_fifo_rules (
  .CLK_IN     (CLK_IN),
  .RESET_IN   (RESET_IN),
  .link_data  (7'b0000000),
  .link_sent  (1'b0),
  .link_acked (1'b0),
  .fifo_full  (fill == fill_bits'(fifo_depth)),
  .fifo_push  (sym_push)
);

`default_nettype wire

/* tb/spl_link_sender_tb.sv */
// ----------------------------------------------------------------------
// directed tests for the link sender with a 2-of-7 link receiver model
// receiver acks each symbol after a queued delay, zero when queue empty
// ----------------------------------------------------------------------
`default_nettype none

module spl_link_sender_tb;
  import spl_pkg::*;

  localparam int fifo_depth   = 4;
  localparam int ack_window   = 1;
  localparam int n_random     = 12;  // packets in the back-to-back test
  localparam int big_delay    = 20;  // largest ack delay, cycles
  localparam int hold_cycles  = 40;  // ack frozen this long in test 5
  localparam int limit_cycles = (n_random + 3) * (long_nibbles + 1) * (big_delay + 8)
                                + hold_cycles + 1000;
  localparam logic [pkt_bits-1:0] short_mask =
    {pkt_bits{1'b1}} >> (pkt_bits - short_nibbles * nibble_bits);

  logic                CLK_IN = 1'b0;
  logic                RESET_IN;
  logic [pkt_bits-1:0] pkt_data;
  logic                pkt_vld;
  logic                pkt_rdy;
  link_t               link_data;
  logic                link_ack = 1'b0;

  logic [31:0]         lfsr = 32'hf8bc_6574;
  int                  errors = 0;     // test side
  int                  rx_errors = 0;  // receiver side
  int                  pkts_ok = 0;
  int                  cycles = 0;
  logic [pkt_bits-1:0] exp_q [$];      // expected payloads, oldest first
  int                  len_q [$];      // expected nibble counts
  int                  delay_q [$];    // ack delays, one per symbol
  link_t               link_prev = '0;
  logic [pkt_bits-1:0] rx_data = '0;   // packet being rebuilt
  int                  rx_cnt = 0;
  int                  sym_seen = 0;   // link changes seen
  int                  sym_acked = 0;  // acks given back
  logic                ack_hold = 1'b0;
  logic                armed = 1'b0;
  int                  ack_wait = 0;

  spl_link_sender #(.fifo_depth(fifo_depth), .ack_window(ack_window)) u_spl_link_sender (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .link_data (link_data),
    .link_ack  (link_ack)
  );

  always #5 CLK_IN = ~CLK_IN;

  // ----------------------------------------------------------------------
  // random source, x^32 + x^22 + x^2 + x + 1
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [pkt_bits-1:0] rand_bits(input int n);
    logic [pkt_bits-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);            // one step per bit
      v = {v[pkt_bits-2:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int total_errors();
    return errors + rx_errors;
  endfunction

  // ----------------------------------------------------------------------
  // link receiver model
  // ----------------------------------------------------------------------
  always @(negedge CLK_IN) begin
    link_t               diff;
    int                  idx;
    logic [pkt_bits-1:0] exp_d;
    int                  exp_n;
    if (!RESET_IN && link_data !== link_prev) begin
      diff      = link_data ^ link_prev;  // nrz, the transition is the symbol
      link_prev = link_data;
      sym_seen  = sym_seen + 1;
      idx       = -1;
      for (int i = 0; i < $size(nrz_code); i++) begin
        if (diff == nrz_code[i]) idx = i;
      end
      if (idx < 0) begin
        $display("link change %b at t=%0t is not a 2-of-7 code", diff, $time);
        rx_errors++;
      end else if (idx == 2 ** nibble_bits) begin  // end of packet
        if (exp_q.size() == 0) begin
          $display("end-of-packet at t=%0t with no packet outstanding", $time);
          rx_errors++;
        end else begin
          exp_d = exp_q.pop_front();
          exp_n = len_q.pop_front();
          if (rx_cnt != exp_n) begin
            $display("ERROR t=%0t rx nibble count: got %0d expected %0d", $time, rx_cnt, exp_n);
            rx_errors++;
          end else if (rx_data !== exp_d) begin
            $display("ERROR t=%0t rx packet: got %h expected %h", $time, rx_data, exp_d);
            rx_errors++;
          end else begin
            pkts_ok++;
          end
        end
        rx_data = '0;
        rx_cnt  = 0;
      end else begin
        rx_data = rx_data | ({{(pkt_bits - nibble_bits){1'b0}}, idx[nibble_bits-1:0]}
                             << (nibble_bits * rx_cnt));  // lsb nibble first
        rx_cnt  = rx_cnt + 1;
      end
    end
  end

  // ack toggles, one per symbol seen
  always @(posedge CLK_IN) begin
    if (!ack_hold) begin
      if (armed) begin
        if (ack_wait == 0) begin
          link_ack  <= ~link_ack;
          sym_acked <= sym_acked + 1;
          armed = 1'b0;
        end else begin
          ack_wait = ack_wait - 1;
        end
      end else if (sym_seen != sym_acked) begin
        armed = 1'b1;
        if (delay_q.size() != 0) ack_wait = delay_q.pop_front();
        else ack_wait = 0;
      end
    end
  end

  // run limit
  always @(posedge CLK_IN) begin
    cycles = cycles + 1;
    if (cycles >= limit_cycles) begin
      $display("timeout after %0d cycles, packets were not all delivered", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  task automatic send_pkt(input logic [pkt_bits-1:0] d);
    @(posedge CLK_IN);
    pkt_data <= d;
    pkt_vld  <= 1'b1;
    if (d[len_bit]) begin
      exp_q.push_back(d);
      len_q.push_back(long_nibbles);
    end else begin
      exp_q.push_back(d & short_mask);  // upper bits never sent
      len_q.push_back(short_nibbles);
    end
    @(negedge CLK_IN);
    while (pkt_rdy !== 1'b1) @(negedge CLK_IN);
    @(posedge CLK_IN);                  // accepted at this edge
    pkt_vld <= 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || sym_seen != sym_acked) @(negedge CLK_IN);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %s", name, (total_errors() == err_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic check_reset_state();
    int e0;
    e0 = total_errors();
    @(negedge CLK_IN);
    if (pkt_rdy !== 1'b1) begin
      $display("ERROR t=%0t pkt_rdy: got %b expected 1", $time, pkt_rdy);
      errors++;
    end
    if (link_data !== '0) begin
      $display("ERROR t=%0t link_data: got %b expected 0000000", $time, link_data);
      errors++;
    end
    report_test("test 1 reset state", e0);
  endtask

  task automatic send_one(input string name, input logic is_long);
    logic [pkt_bits-1:0] d;
    int                  e0;
    e0 = total_errors();
    d = rand_bits(pkt_bits);
    d[len_bit] = is_long;
    send_pkt(d);
    wait_drain();
    report_test(name, e0);
  endtask

  task automatic send_random_stream();
    int e0;
    e0 = total_errors();
    for (int i = 0; i < n_random * (long_nibbles + 1); i++) begin
      delay_q.push_back(int'(rand_bits(5)) % (big_delay + 1));
    end
    for (int i = 0; i < n_random; i++) begin
      send_pkt(rand_bits(pkt_bits));    // length bit random too
    end
    wait_drain();
    delay_q.delete();
    report_test("test 4 random stream", e0);
  endtask

  task automatic stall_on_ack_hold();
    logic [pkt_bits-1:0] d;
    int                  e0;
    int                  base;
    int                  mid;
    e0 = total_errors();
    d = rand_bits(pkt_bits);
    d[len_bit] = 1'b1;
    @(negedge CLK_IN);
    ack_hold = 1'b1;
    base = sym_seen;
    send_pkt(d);
    repeat (hold_cycles / 2) @(negedge CLK_IN);
    mid = sym_seen;
    repeat (hold_cycles / 2) @(negedge CLK_IN);
    if (sym_seen - base > ack_window) begin
      $display("ERROR t=%0t link changes while ack held: got %0d expected at most %0d",
               $time, sym_seen - base, ack_window);
      errors++;
    end
    if (sym_seen != mid) begin
      $display("link_data kept changing while the acknowledge was held");
      errors++;
    end
    if (pkt_rdy !== 1'b0) begin
      $display("ERROR t=%0t pkt_rdy: got %b expected 0", $time, pkt_rdy);
      errors++;
    end
    ack_hold = 1'b0;                    // let the packet finish
    wait_drain();
    report_test("test 5 ack stall", e0);
  endtask

  initial begin
    RESET_IN = 1'b1;
    pkt_data = '0;
    pkt_vld  = 1'b0;
    repeat (8) @(posedge CLK_IN);
    RESET_IN <= 1'b0;
    check_reset_state();
    send_one("test 2 short packet", 1'b0);
    send_one("test 3 long packet", 1'b1);
    send_random_stream();
    stall_on_ack_hold();
    $display("%0d packets received intact, %0d errors", pkts_ok, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
src/spl_pkg.sv
src/spl_pkt_serializer.sv
src/spl_symbol_fifo.sv
src/spl_link_transmitter.sv
src/spl_link_sender.sv
tb/spl_link_sender_assert.sv
tb/spl_link_sender_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the link sender testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sources.f --top-module spl_link_sender_tb \
  -o spl_link_sender_sim

# an assertion failure ends the run early, the output is shown either way
out=$(./obj_dir/spl_link_sender_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Simulation finished: PASS'; then
  exit 0
fi
exit 1
